// ==== common/csr_pkg.sv ====
package csr_pkg;

  // basic widths
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // machine-mode csr addresses
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;

  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // read-only id values
  localparam csr_data_t MVENDORID_VAL = 32'h79737978;
  localparam csr_data_t MARCHID_VAL   = 32'h015fde77;

  // environment call from M-mode
  localparam csr_data_t CAUSE_ECALL_M = 32'd11;

  // SYSTEM opcode and its funct3 encodings
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] FUNCT3_PRIV   = 3'b000;
  localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
  localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
  localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
  localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
  localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
  localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

  // funct12 for the privileged forms
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

  // decoded operation
  typedef enum logic [2:0] {
    CSR_NONE  = 3'd0,
    CSR_RW    = 3'd1,
    CSR_RS    = 3'd2,
    CSR_RC    = 3'd3,
    CSR_ECALL = 3'd4,
    CSR_MRET  = 3'd5
  } csr_op_e;

endpackage

// ==== common/csr_write_if.sv ====
`timescale 1ns/1ps

interface csr_write_if import csr_pkg::*; ();

  // main write port
  logic      wen;
  csr_addr_t waddr;
  csr_data_t wdata;

  // second write port, only used on trap entry
  logic      wen2;
  csr_addr_t waddr2;
  csr_data_t wdata2;

  // trap strobes
  logic      ecall;
  logic      mret;

  csr_addr_t raddr;

  modport exec (
    output wen, waddr, wdata,
    output wen2, waddr2, wdata2,
    output ecall, mret,
    output raddr
  );

  modport regfile (
    input wen, waddr, wdata,
    input wen2, waddr2, wdata2,
    input ecall, mret,
    input raddr
  );

endinterface

// ==== csr_regfile/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile import csr_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  csr_write_if.regfile      wr,
  output csr_data_t         rdata,
  output csr_data_t         mepc,
  output csr_data_t         mtvec
);

  // one-hot select over the writable csrs
  localparam int SEL_MSTATUS = 0;
  localparam int SEL_MTVEC   = 1;
  localparam int SEL_MEPC    = 2;
  localparam int SEL_MCAUSE  = 3;

  csr_data_t  mstatus_q;
  csr_data_t  mtvec_q;
  csr_data_t  mepc_q;
  csr_data_t  mcause_q;

  logic [3:0] sel1;
  logic [3:0] sel2;

  // read-only and unknown addresses never select a register
  function automatic logic [3:0] csr_sel(input csr_addr_t addr);
    logic [3:0] sel;
    sel = '0;
    case (addr)
      CSR_MSTATUS: sel[SEL_MSTATUS] = 1'b1;
      CSR_MTVEC:   sel[SEL_MTVEC]   = 1'b1;
      CSR_MEPC:    sel[SEL_MEPC]    = 1'b1;
      CSR_MCAUSE:  sel[SEL_MCAUSE]  = 1'b1;
      default:     sel = '0;
    endcase
    return sel;
  endfunction

  assign sel1 = wr.wen  ? csr_sel(wr.waddr)  : 4'b0000;
  assign sel2 = wr.wen2 ? csr_sel(wr.waddr2) : 4'b0000;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      // second port wins on a clash
      if (sel2[SEL_MSTATUS]) begin
        mstatus_q <= wr.wdata2;
      end else if (sel1[SEL_MSTATUS]) begin
        mstatus_q <= wr.wdata;
      end

      // direct mode only, base kept word aligned
      if (sel2[SEL_MTVEC]) begin
        mtvec_q <= {wr.wdata2[31:2], 2'b00};
      end else if (sel1[SEL_MTVEC]) begin
        mtvec_q <= {wr.wdata[31:2], 2'b00};
      end

      if (sel2[SEL_MEPC]) begin
        mepc_q <= wr.wdata2;
      end else if (sel1[SEL_MEPC]) begin
        mepc_q <= wr.wdata;
      end

      if (sel2[SEL_MCAUSE]) begin
        mcause_q <= wr.wdata2;
      end else if (sel1[SEL_MCAUSE]) begin
        mcause_q <= wr.wdata;
      end

      // trap entry and return touch only the interrupt enable stack
      if (wr.ecall) begin
        mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
        mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
      end else if (wr.mret) begin
        mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
        mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
      end
    end
  end

  always_comb begin
    case (wr.raddr)
      CSR_MVENDORID: rdata = MVENDORID_VAL;
      CSR_MARCHID:   rdata = MARCHID_VAL;
      CSR_MSTATUS:   rdata = mstatus_q;
      CSR_MTVEC:     rdata = mtvec_q;
      CSR_MEPC:      rdata = mepc_q;
      CSR_MCAUSE:    rdata = mcause_q;
      default:       rdata = '0;
    endcase
  end

  assign mepc  = mepc_q;
  assign mtvec = mtvec_q;

  // decode in execute must never raise both trap strobes
  a_ecall_mret_excl: assert property (
    @(posedge clk) disable iff (rst) !(wr.ecall && wr.mret)
  );

  // second port is reserved for trap entry
  a_wen2_only_ecall: assert property (
    @(posedge clk) disable iff (rst) wr.wen2 |-> wr.ecall
  );

  a_mtvec_aligned: assert property (
    @(posedge clk) disable iff (rst)
    (sel1[SEL_MTVEC] || sel2[SEL_MTVEC]) |=> (mtvec_q[1:0] == 2'b00)
  );

endmodule

// ==== hdl/csr_exec.sv ====
`timescale 1ns/1ps

module csr_exec import csr_pkg::*; (
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  csr_data_t   pc,
  input  csr_data_t   rs1_data,
  input  csr_data_t   rdata,
  csr_write_if.exec   wr,
  output csr_data_t   rd_data,
  output csr_op_e     op
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rs1_idx;
  logic [12:0] priv_zero;
  csr_addr_t   csr_addr;
  logic        is_imm;
  csr_data_t   operand;

  // instruction fields
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign rs1_idx   = instr[19:15];
  assign csr_addr  = instr[31:20];
  assign priv_zero = instr[19:7];

  // immediate forms reuse the rs1 field as a 5-bit uimm
  assign is_imm  = funct3[2];
  assign operand = is_imm ? {27'd0, rs1_idx} : rs1_data;

  always_comb begin
    op = CSR_NONE;
    if (instr_valid && opcode == OPC_SYSTEM) begin
      case (funct3)
        FUNCT3_CSRRW, FUNCT3_CSRRWI: op = CSR_RW;
        FUNCT3_CSRRS, FUNCT3_CSRRSI: op = CSR_RS;
        FUNCT3_CSRRC, FUNCT3_CSRRCI: op = CSR_RC;
        FUNCT3_PRIV: begin
          if (priv_zero == '0) begin
            if (csr_addr == FUNCT12_ECALL) begin
              op = CSR_ECALL;
            end else if (csr_addr == FUNCT12_MRET) begin
              op = CSR_MRET;
            end
          end
        end
        default: op = CSR_NONE;
      endcase
    end
  end

  assign wr.raddr = csr_addr;

  always_comb begin
    wr.wen    = 1'b0;
    wr.waddr  = csr_addr;
    wr.wdata  = operand;
    wr.wen2   = 1'b0;
    wr.waddr2 = CSR_MCAUSE;
    wr.wdata2 = CAUSE_ECALL_M;
    wr.ecall  = 1'b0;
    wr.mret   = 1'b0;
    case (op)
      CSR_RW: begin
        wr.wen = 1'b1;
      end
      // x0 or a zero uimm means read only
      CSR_RS: begin
        wr.wen   = (rs1_idx != 5'd0);
        wr.wdata = rdata | operand;
      end
      CSR_RC: begin
        wr.wen   = (rs1_idx != 5'd0);
        wr.wdata = rdata & ~operand;
      end
      CSR_ECALL: begin
        wr.wen   = 1'b1;
        wr.waddr = CSR_MEPC;
        wr.wdata = pc;
        wr.wen2  = 1'b1;
        wr.ecall = 1'b1;
      end
      CSR_MRET: begin
        wr.mret = 1'b1;
      end
      default: begin
        wr.wen = 1'b0;
      end
    endcase
  end

  // old value goes back to rd only for the csr forms
  assign rd_data = (op == CSR_RW || op == CSR_RS || op == CSR_RC) ? rdata : '0;

  always_comb begin
    a_wen_mret_excl: assert final (!(wr.wen && wr.mret));
  end

endmodule

// ==== hdl/trap_redirect.sv ====
`timescale 1ns/1ps

module trap_redirect import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  csr_op_e   op,
  input  csr_data_t mepc,
  input  csr_data_t mtvec,
  output logic      redirect_valid,
  output csr_data_t redirect_pc
);

  logic      is_trap;
  csr_data_t target;

  assign is_trap = (op == CSR_ECALL) || (op == CSR_MRET);

  // sample the target in the instruction's own cycle,
  // before the regfile applies that instruction's writes
  always_comb begin
    case (op)
      CSR_ECALL: target = mtvec;
      CSR_MRET:  target = mepc;
      default:   target = redirect_pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= is_trap;
    end
  end

  // holds the last target between pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_pc <= '0;
    end else if (is_trap) begin
      redirect_pc <= target;
    end
  end

endmodule

// ==== hdl/csr_unit_top.sv ====
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  csr_data_t   pc,
  input  csr_data_t   rs1_data,
  output csr_data_t   rd_data,
  output logic        redirect_valid,
  output csr_data_t   redirect_pc
);

  csr_data_t rdata;
  csr_data_t mepc;
  csr_data_t mtvec;
  csr_op_e   op;

  csr_write_if wr_if ();

  // decode and write-back, zero cycles
  csr_exec exec_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rdata       (rdata),
    .wr          (wr_if.exec),
    .rd_data     (rd_data),
    .op          (op)
  );

  csr_regfile regfile_i (
    .clk   (clk),
    .rst   (rst),
    .wr    (wr_if.regfile),
    .rdata (rdata),
    .mepc  (mepc),
    .mtvec (mtvec)
  );

  // redirect target lands one cycle after ecall or mret
  trap_redirect redirect_i (
    .clk            (clk),
    .rst            (rst),
    .op             (op),
    .mepc           (mepc),
    .mtvec          (mtvec),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 8 + 5 * 80 + 20;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  csr_data_t   pc;
  csr_data_t   rs1_data;
  csr_data_t   rd_data;
  logic        redirect_valid;
  csr_data_t   redirect_pc;

  // shadow copy of the writable csrs
  csr_data_t   sh_mstatus;
  csr_data_t   sh_mtvec;
  csr_data_t   sh_mepc;
  csr_data_t   sh_mcause;

  // expectations, set together with the inputs
  logic        check_rd;
  csr_data_t   exp_rd;
  logic        exp_trap;
  csr_data_t   exp_target;
  logic        prev_trap;
  csr_data_t   prev_target;

  string       test_name;
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  csr_addr_t   addr_pool [7];
  logic [2:0]  f3_pool [6];

  csr_unit_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .rs1_data       (rs1_data),
    .rd_data        (rd_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] csr_word(input logic [2:0] f3, input csr_addr_t addr,
                                           input logic [4:0] src);
    return {addr, src, f3, 5'd1, OPC_SYSTEM};
  endfunction

  function automatic csr_data_t shadow_read(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:   return sh_mstatus;
      CSR_MTVEC:     return sh_mtvec;
      CSR_MEPC:      return sh_mepc;
      CSR_MCAUSE:    return sh_mcause;
      CSR_MVENDORID: return MVENDORID_VAL;
      CSR_MARCHID:   return MARCHID_VAL;
      default:       return '0;
    endcase
  endfunction

  task automatic shadow_write(input csr_addr_t addr, input csr_data_t val);
    case (addr)
      CSR_MSTATUS: sh_mstatus = val;
      CSR_MTVEC:   sh_mtvec   = {val[31:2], 2'b00};
      CSR_MEPC:    sh_mepc    = val;
      CSR_MCAUSE:  sh_mcause  = val;
      default:     sh_mstatus = sh_mstatus;
    endcase
  endtask

  // one csr instruction, then wait for the next drive point
  task automatic do_csr(input logic [2:0] f3, input csr_addr_t addr, input logic [4:0] src,
                        input csr_data_t rs1_val);
    csr_data_t old_val;
    csr_data_t opnd;
    old_val = shadow_read(addr);
    opnd = f3[2] ? {27'd0, src} : rs1_val;
    check_rd = 1'b1;
    exp_rd = old_val;
    exp_trap = 1'b0;
    if (f3[1:0] == 2'b01) begin
      shadow_write(addr, opnd);
    end else if (f3[1:0] == 2'b10 && src != 5'd0) begin
      shadow_write(addr, old_val | opnd);
    end else if (f3[1:0] == 2'b11 && src != 5'd0) begin
      shadow_write(addr, old_val & ~opnd);
    end
    instr_valid = 1'b1;
    instr = csr_word(f3, addr, src);
    rs1_data = rs1_val;
    @(posedge clk);
    #2;
  endtask

  task automatic do_ecall(input csr_data_t pc_val);
    check_rd = 1'b0;
    exp_trap = 1'b1;
    exp_target = sh_mtvec;
    sh_mepc = pc_val;
    sh_mcause = CAUSE_ECALL_M;
    sh_mstatus[MSTATUS_MPIE_BIT] = sh_mstatus[MSTATUS_MIE_BIT];
    sh_mstatus[MSTATUS_MIE_BIT] = 1'b0;
    instr_valid = 1'b1;
    instr = {FUNCT12_ECALL, 13'd0, OPC_SYSTEM};
    pc = pc_val;
    @(posedge clk);
    #2;
  endtask

  task automatic do_mret();
    check_rd = 1'b0;
    exp_trap = 1'b1;
    exp_target = sh_mepc;
    sh_mstatus[MSTATUS_MIE_BIT] = sh_mstatus[MSTATUS_MPIE_BIT];
    sh_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
    instr_valid = 1'b1;
    instr = {FUNCT12_MRET, 13'd0, OPC_SYSTEM};
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycle();
    check_rd = 1'b0;
    exp_trap = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    @(posedge clk);
    #2;
  endtask

  // redirect expectation trails the instruction by one cycle
  always @(posedge clk) begin
    prev_trap <= exp_trap;
    prev_target <= exp_target;
  end

  a_rd_data: assert property (@(posedge clk) disable iff (rst) check_rd |-> rd_data == exp_rd)
    else begin
      $display("ERR %s rd_data expected %h actual %h", test_name, $sampled(exp_rd),
               $sampled(rd_data));
      $display(">>> FAIL");
      $fatal(1, "rd_data mismatch");
    end

  a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
    redirect_valid == prev_trap)
    else begin
      $display("ERR %s redirect_valid expected %b actual %b", test_name, $sampled(prev_trap),
               $sampled(redirect_valid));
      $display(">>> FAIL");
      $fatal(1, "redirect_valid mismatch");
    end

  a_redirect_pc: assert property (@(posedge clk) disable iff (rst)
    prev_trap |-> redirect_pc == prev_target)
    else begin
      $display("ERR %s redirect_pc expected %h actual %h", test_name, $sampled(prev_target),
               $sampled(redirect_pc));
      $display(">>> FAIL");
      $fatal(1, "redirect_pc mismatch");
    end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] r;
    csr_addr_t   addr;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    pc = '0;
    rs1_data = '0;
    check_rd = 1'b0;
    exp_rd = '0;
    exp_trap = 1'b0;
    exp_target = '0;
    prev_trap = 1'b0;
    prev_target = '0;
    sh_mstatus = '0;
    sh_mtvec = '0;
    sh_mepc = '0;
    sh_mcause = '0;
    lcg_state = 32'hd5b5;
    test_name = "reset";
    addr_pool = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MVENDORID, CSR_MARCHID,
                  12'h7C0};
    f3_pool = '{FUNCT3_CSRRW, FUNCT3_CSRRS, FUNCT3_CSRRC, FUNCT3_CSRRWI, FUNCT3_CSRRSI,
                FUNCT3_CSRRCI};
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    test_name = "reset_ids";
    foreach (addr_pool[i]) begin
      do_csr(FUNCT3_CSRRS, addr_pool[i], 5'd0, 32'hffff_ffff);
    end

    test_name = "rmw";
    for (int i = 0; i < 24; i++) begin
      r = lcg_next();
      addr = addr_pool[r[31:16] % 7];
      do_csr(f3_pool[r[15:8] % 6], addr, r[4:0], lcg_next());
      do_csr(FUNCT3_CSRRS, addr, 5'd0, lcg_next());
    end
    // read-only targets and x0 sources must not write
    do_csr(FUNCT3_CSRRW, CSR_MVENDORID, 5'd3, 32'h1234_5678);
    do_csr(FUNCT3_CSRRW, CSR_MARCHID, 5'd3, 32'h8765_4321);
    do_csr(FUNCT3_CSRRS, CSR_MTVEC, 5'd0, 32'hffff_ffff);
    do_csr(FUNCT3_CSRRC, CSR_MEPC, 5'd0, 32'hffff_ffff);
    do_csr(FUNCT3_CSRRS, CSR_MVENDORID, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MTVEC, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MEPC, 5'd0, '0);

    test_name = "ecall";
    do_csr(FUNCT3_CSRRW, CSR_MTVEC, 5'd2, 32'h0000_1237);
    do_csr(FUNCT3_CSRRW, CSR_MSTATUS, 5'd2, 32'h0000_0000);
    do_csr(FUNCT3_CSRRSI, CSR_MSTATUS, 5'd8, '0);
    do_ecall(lcg_next());
    idle_cycle();
    do_csr(FUNCT3_CSRRS, CSR_MEPC, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MCAUSE, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MSTATUS, 5'd0, '0);

    test_name = "mret";
    do_csr(FUNCT3_CSRRW, CSR_MEPC, 5'd4, 32'h0000_8a40);
    // MIE set, MPIE clear, so the return pulls a zero into MIE
    do_csr(FUNCT3_CSRRW, CSR_MSTATUS, 5'd4, 32'h0000_0008);
    do_mret();
    idle_cycle();
    do_csr(FUNCT3_CSRRS, CSR_MSTATUS, 5'd0, '0);

    test_name = "back_to_back";
    do_csr(FUNCT3_CSRRW, CSR_MTVEC, 5'd5, 32'h0000_0400);
    do_csr(FUNCT3_CSRRSI, CSR_MSTATUS, 5'd8, '0);
    do_ecall(32'h0000_2000);
    do_ecall(32'h0000_2004);
    do_ecall(32'h0000_3008);
    do_csr(FUNCT3_CSRRW, CSR_MTVEC, 5'd5, 32'h0000_0800);
    do_mret();
    idle_cycle();
    idle_cycle();
    do_csr(FUNCT3_CSRRS, CSR_MEPC, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MCAUSE, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MSTATUS, 5'd0, '0);
    do_csr(FUNCT3_CSRRS, CSR_MTVEC, 5'd0, '0);
    idle_cycle();
    idle_cycle();

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
common/csr_pkg.sv
common/csr_write_if.sv
csr_regfile/csr_regfile.sv
hdl/csr_exec.sv
hdl/trap_redirect.sv
hdl/csr_unit_top.sv
dv/csr_unit_tb.sv
